//--- source/mipsPkg.sv
package mipsPkg;

    // Primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_BEQ   = 6'b000100,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_t;

    // R-type function field, instr[5:0]
    typedef enum logic [5:0] {
        FN_ADD = 6'b100000,
        FN_SUB = 6'b100010,
        FN_AND = 6'b100100,
        FN_OR  = 6'b100101,
        FN_SLT = 6'b101010
    } funct_t;

    // ALU control encoding
    typedef enum logic [3:0] {
        ALU_AND = 4'b0000,
        ALU_OR  = 4'b0001,
        ALU_ADD = 4'b0010,
        ALU_SUB = 4'b0110,
        ALU_SLT = 4'b0111
    } aluOp_t;

    // Next pc source
    typedef enum logic [1:0] {
        PC_NEXT   = 2'b00,
        PC_BRANCH = 2'b01,
        PC_JUMP   = 2'b10
    } pcSrc_t;

    localparam int DMEM_WORDS = 64;        // Data memory depth in words
    localparam int DMEM_AW    = 6;         // Word address width
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

endpackage

//--- source/ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf;
    import mipsPkg::*;

    logic   regWrite;      // Register file write enable
    aluOp_t aluOperation;  // ALU function
    logic   memWrite;      // Data memory store
    pcSrc_t pcSrc;         // Next pc selection
    logic   aluSrc;        // Immediate as ALU operand B
    logic   regDst;        // rd instead of rt as destination

    modport decoder (
        output regWrite, aluOperation, memWrite,
        output pcSrc, aluSrc, regDst
    );

    modport consumer (
        input regWrite, aluOperation, memWrite,
        input pcSrc, aluSrc, regDst
    );

endinterface

//--- source/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  mipsPkg::opcode_t opcode,
    input  mipsPkg::funct_t  funct,
    ctrlIf.decoder           ctrl
);
    import mipsPkg::*;

    always_comb begin
        // Defaults describe a no-effect instruction
        ctrl.regWrite     = 1'b0;
        ctrl.memWrite     = 1'b0;
        ctrl.aluSrc       = 1'b0;
        ctrl.regDst       = 1'b0;
        ctrl.pcSrc        = PC_NEXT;
        ctrl.aluOperation = ALU_AND;

        case (opcode)
            OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = 1'b1;        // Write rd
                case (funct)
                    FN_ADD:  ctrl.aluOperation = ALU_ADD;
                    FN_SUB:  ctrl.aluOperation = ALU_SUB;
                    FN_AND:  ctrl.aluOperation = ALU_AND;
                    FN_OR:   ctrl.aluOperation = ALU_OR;
                    FN_SLT:  ctrl.aluOperation = ALU_SLT;
                    default: ctrl.aluOperation = ALU_AND; // Unknown funct acts as AND
                endcase
            end

            OP_LW: begin
                ctrl.regWrite     = 1'b1;
                ctrl.aluSrc       = 1'b1;
                ctrl.aluOperation = ALU_ADD;   // Base plus offset
            end

            OP_SW: begin
                ctrl.memWrite     = 1'b1;
                ctrl.aluSrc       = 1'b1;
                ctrl.aluOperation = ALU_ADD;   // Base plus offset
            end

            OP_BEQ: begin
                ctrl.pcSrc        = PC_BRANCH;
                ctrl.aluOperation = ALU_SUB;   // Zero result means equal
            end

            OP_J: begin
                ctrl.pcSrc = PC_JUMP;
            end

            default: begin
                // Unlisted opcode retires with no effect
                ctrl.pcSrc = PC_NEXT;
            end
        endcase
    end

endmodule

//--- source/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic        arstN,
    input  logic [4:0]  rs,
    input  logic [4:0]  rt,
    output logic [31:0] rsData,
    output logic [31:0] rtData,
    input  logic        wrEn,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData
);

    logic [31:0] regs [32];

    // Asynchronous read ports
    assign rsData = regs[rs];
    assign rtData = regs[rt];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != 5'd0)) begin
            regs[wrAddr] <= wrData;     // $0 stays zero
        end
    end

endmodule

//--- source/executeUnit.sv
`timescale 1ns/1ps

module executeUnit (
    input  logic        clk,
    input  logic        arstN,
    ctrlIf.consumer     ctrl,
    input  logic [31:0] instr,
    input  logic [31:0] rsData,
    input  logic [31:0] rtData,
    input  logic        commit,
    output logic [31:0] pc,
    output logic        wrEn,
    output logic [4:0]  wrAddr,
    output logic [31:0] wrData,
    output logic        memWriteOut,
    output logic [31:0] memAddr,
    output logic [31:0] storeData
);
    import mipsPkg::*;

    opcode_t     opcode;
    logic [31:0] immExt;
    logic [31:0] operandB;
    logic [31:0] aluResult;
    logic [31:0] loadData;
    logic [31:0] pcPlus4;
    logic [31:0] nextPc;
    logic [31:0] dmem [DMEM_WORDS];

    assign opcode   = opcode_t'(instr[31:26]);
    assign immExt   = {{16{instr[15]}}, instr[15:0]};   // Sign extend
    assign operandB = ctrl.aluSrc ? immExt : rtData;

    always_comb begin
        case (ctrl.aluOperation)
            ALU_AND: aluResult = rsData & operandB;
            ALU_OR:  aluResult = rsData | operandB;
            ALU_ADD: aluResult = rsData + operandB;
            ALU_SUB: aluResult = rsData - operandB;
            ALU_SLT: aluResult = {31'd0, $signed(rsData) < $signed(operandB)};
            default: aluResult = '0;
        endcase
    end

    // Data memory, word indexed
    assign loadData = dmem[aluResult[DMEM_AW+1:2]];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (commit && ctrl.memWrite) begin
            dmem[aluResult[DMEM_AW+1:2]] <= rtData;
        end
    end

    // Writeback, never reported for $0
    assign wrAddr = ctrl.regDst ? instr[15:11] : instr[20:16];
    assign wrEn   = ctrl.regWrite && (wrAddr != 5'd0);
    assign wrData = (opcode == OP_LW) ? loadData : aluResult;

    assign memWriteOut = ctrl.memWrite;
    assign memAddr     = aluResult;
    assign storeData   = rtData;

    // Next pc
    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (ctrl.pcSrc)
            PC_BRANCH: nextPc = (aluResult == '0) ? pcPlus4 + {immExt[29:0], 2'b00}
                                                  : pcPlus4;
            PC_JUMP:   nextPc = {pcPlus4[31:28], instr[25:0], 2'b00};
            default:   nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= RESET_PC;
        end else if (commit) begin
            pc <= nextPc;               // Only moves when both ports fire
        end
    end

endmodule

//--- source/mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
    input  logic        clk,
    input  logic        arstN,
    // Instruction port
    input  logic        instrValid,
    input  logic [31:0] instr,
    output logic        instrReady,
    // Retire port
    output logic        retireValid,
    output logic [31:0] retirePc,
    output logic        retireRegWrite,
    output logic [4:0]  retireReg,
    output logic [31:0] retireData,
    output logic        retireMemWrite,
    output logic [31:0] retireAddr,
    output logic [31:0] retireStoreData,
    input  logic        retireReady,
    // Fetch address
    output logic [31:0] pc
);
    import mipsPkg::*;

    opcode_t     opcode;
    funct_t      funct;
    logic        commit;
    logic [31:0] rsData;
    logic [31:0] rtData;
    logic        wrEn;
    logic [4:0]  wrAddr;
    logic [31:0] wrData;

    ctrlIf ctrlBus ();

    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = funct_t'(instr[5:0]);

    // Accept and retire fire together
    assign instrReady  = retireReady;
    assign retireValid = instrValid;
    assign commit      = instrValid && retireReady;

    controlUnit controlUnit_inst (
        .opcode (opcode),
        .funct  (funct),
        .ctrl   (ctrlBus.decoder)
    );

    regFile regFile_inst (
        .clk    (clk),
        .arstN  (arstN),
        .rs     (instr[25:21]),
        .rt     (instr[20:16]),
        .rsData (rsData),
        .rtData (rtData),
        .wrEn   (wrEn && commit),      // Write only on commit
        .wrAddr (wrAddr),
        .wrData (wrData)
    );

    executeUnit executeUnit_inst (
        .clk         (clk),
        .arstN       (arstN),
        .ctrl        (ctrlBus.consumer),
        .instr       (instr),
        .rsData      (rsData),
        .rtData      (rtData),
        .commit      (commit),
        .pc          (pc),
        .wrEn        (wrEn),
        .wrAddr      (wrAddr),
        .wrData      (wrData),
        .memWriteOut (retireMemWrite),
        .memAddr     (retireAddr),
        .storeData   (retireStoreData)
    );

    assign retirePc       = pc;
    assign retireRegWrite = wrEn;
    assign retireReg      = wrAddr;
    assign retireData     = wrData;

endmodule

//--- testbench/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // 8 ns period
    end

    initial begin
        arstN = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;               // Release away from the active edge
    end

endmodule

//--- testbench/mipsCore_assert.sv
`timescale 1ns/1ps

module mipsCoreAssert (
    input logic        clk,
    input logic        arstN,
    input logic        instrValid,
    input logic        instrReady,
    input logic        retireValid,
    input logic        retireReady,
    input logic        retireRegWrite,
    input logic [4:0]  retireReg,
    input logic [31:0] pc
);

    logic commit;

    assign commit = instrValid && instrReady;

    validTied: assert property (@(posedge clk) disable iff (!arstN)
        retireValid == instrValid)
        else $error("retireValid does not follow instrValid");

    readyTied: assert property (@(posedge clk) disable iff (!arstN)
        instrReady == retireReady)
        else $error("instrReady does not follow retireReady");

    // Fetch address only moves on a commit
    pcHeld: assert property (@(posedge clk) disable iff (!arstN)
        !commit |=> $stable(pc))
        else $error("pc changed without a commit");

    noZeroWrite: assert property (@(posedge clk) disable iff (!arstN)
        retireRegWrite |-> retireReg != 5'd0)
        else $error("Register write to $0 reported on retire port");

endmodule

//--- testbench/mipsCoreTb.sv
`timescale 1ns/1ps

module mipsCoreTb;
    import mipsPkg::*;

    localparam int NUM_COMMITS    = 400;
    localparam int TIMEOUT_CYCLES = NUM_COMMITS * 16 + 10;
    localparam int PROG_LEN       = 64;
    localparam logic [15:0] LFSR_SEED = 16'd38304;

    typedef struct packed {
        logic        regWrite;
        logic [4:0]  regNum;
        logic [31:0] data;
        logic        memWrite;
        logic [31:0] addr;
        logic [31:0] storeData;
        logic [31:0] nextPc;
    } retireInfo_t;

    logic        clk;
    logic        arstN;
    logic        instrValid;
    logic [31:0] instr;
    logic        instrReady;
    logic        retireValid;
    logic [31:0] retirePc;
    logic        retireRegWrite;
    logic [4:0]  retireReg;
    logic [31:0] retireData;
    logic        retireMemWrite;
    logic [31:0] retireAddr;
    logic [31:0] retireStoreData;
    logic        retireReady;
    logic [31:0] pc;

    logic [15:0] lfsrState;
    logic [31:0] progMem [PROG_LEN];
    logic [31:0] modelRegs [32];
    logic [31:0] modelMem [DMEM_WORDS];
    logic [31:0] modelPc;
    retireInfo_t expRetire;
    int          commitCount;
    int          cycleCount;

    clockGen clockGen_inst (.clk(clk), .arstN(arstN));

    mipsCore mipsCore_inst (.*);

    bind mipsCore mipsCoreAssert coreAssert (
        .clk(clk), .arstN(arstN), .instrValid(instrValid), .instrReady(instrReady),
        .retireValid(retireValid), .retireReady(retireReady),
        .retireRegWrite(retireRegWrite), .retireReg(retireReg), .pc(pc)
    );

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] randBits(input int n);
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            r = {r[14:0], lfsrState[0]};    // One step per bit
        end
        return r;
    endfunction

    function automatic logic [31:0] drawInstr(input int idx);
        logic [15:0] kind;
        logic [15:0] r;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [5:0]  target;
        logic [5:0]  fnBits;
        logic [31:0] word;
        int          diff;
        kind = randBits(4);
        r = randBits(3);
        rs = r[4:0];
        r = randBits(3);
        rt = r[4:0];
        r = randBits(3);
        rd = r[4:0];
        r = randBits(6);
        target = r[5:0];
        r = randBits(3);
        case (r[2:0])
            3'd0, 3'd5: fnBits = FN_ADD;
            3'd1, 3'd6: fnBits = FN_SUB;
            3'd2:       fnBits = FN_AND;
            3'd3, 3'd7: fnBits = FN_OR;
            default:    fnBits = FN_SLT;
        endcase
        diff = int'(target) - idx - 1;      // Branch offset in words
        case (kind[3:0])
            4'd7, 4'd8:  word = {OP_LW, 5'd0, rt, 8'd0, target, 2'b00};
            4'd9, 4'd10: word = {OP_SW, 5'd0, rt, 8'd0, target, 2'b00};
            4'd11:       word = {OP_BEQ, rs, rt, diff[15:0]};
            4'd12:       word = {OP_J, 20'd0, target};
            4'd13:       word = {r[1] ? 6'b001000 : 6'b001101, rs, rt, 8'd0, target, 2'b00};
            4'd14:       word = {OP_RTYPE, rs, rt, rd, 5'd0, r[0] ? 6'b100111 : 6'b000000};
            default:     word = {OP_RTYPE, rs, rt, rd, 5'd0, fnBits};
        endcase
        return word;
    endfunction

    // Reference model, one committed instruction per call
    function automatic retireInfo_t stepModel(input logic [31:0] ins);
        retireInfo_t res;
        opcode_t     op;
        funct_t      fn;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] alu;
        logic [31:0] pcPlus4;
        op = opcode_t'(ins[31:26]);
        fn = funct_t'(ins[5:0]);
        a = modelRegs[ins[25:21]];
        b = modelRegs[ins[20:16]];
        imm = {{16{ins[15]}}, ins[15:0]};
        alu = a + imm;                      // Effective address for LW and SW
        pcPlus4 = modelPc + 32'd4;
        res = '0;
        res.nextPc = pcPlus4;
        case (op)
            OP_RTYPE: begin
                case (fn)
                    FN_ADD:  res.data = a + b;
                    FN_SUB:  res.data = a - b;
                    FN_OR:   res.data = a | b;
                    FN_SLT:  res.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: res.data = a & b;  // AND and unlisted functs
                endcase
                res.regWrite = 1'b1;
                res.regNum = ins[15:11];
            end
            OP_LW: begin
                res.regWrite = 1'b1;
                res.regNum = ins[20:16];
                res.data = modelMem[alu[DMEM_AW+1:2]];
            end
            OP_SW: begin
                res.memWrite = 1'b1;
                res.addr = alu;
                res.storeData = b;
            end
            OP_BEQ: begin
                if (a == b) begin
                    res.nextPc = pcPlus4 + {imm[29:0], 2'b00};
                end
            end
            OP_J: res.nextPc = {pcPlus4[31:28], ins[25:0], 2'b00};
            default: res.nextPc = pcPlus4;
        endcase
        if (res.regNum == 5'd0) begin
            res.regWrite = 1'b0;            // $0 is never written
        end
        if (res.regWrite) begin
            modelRegs[res.regNum] = res.data;
        end
        if (res.memWrite) begin
            modelMem[res.addr[DMEM_AW+1:2]] = res.storeData;
        end
        modelPc = res.nextPc;
        return res;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Errors found");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    initial begin
        logic [15:0] coin;
        instrValid = 1'b0;
        retireReady = 1'b0;
        instr = '0;
        lfsrState = LFSR_SEED;
        for (int i = 0; i < PROG_LEN; i++) begin
            progMem[i] = drawInstr(i);
        end
        @(posedge arstN);
        forever begin
            @(negedge clk);
            coin = randBits(1);
            instrValid <= coin[0];
            coin = randBits(1);
            retireReady <= coin[0];
            instr <= progMem[pc[7:2]];      // Wraps modulo 64
        end
    end

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                modelRegs[i] = '0;
            end
            for (int i = 0; i < DMEM_WORDS; i++) begin
                modelMem[i] = '0;
            end
            modelPc = RESET_PC;
            commitCount = 0;
            cycleCount = 0;
        end else begin
            cycleCount++;
            checkValue("pc", pc, modelPc);  // Also holds while stalled
            checkValue("instrReady", {31'd0, instrReady}, {31'd0, retireReady});
            checkValue("retireValid", {31'd0, retireValid}, {31'd0, instrValid});
            if (instrValid && instrReady) begin
                checkValue("retirePc", retirePc, modelPc);
                expRetire = stepModel(instr);
                checkValue("retireRegWrite", {31'd0, retireRegWrite},
                           {31'd0, expRetire.regWrite});
                if (expRetire.regWrite) begin
                    checkValue("retireReg", {27'd0, retireReg}, {27'd0, expRetire.regNum});
                    checkValue("retireData", retireData, expRetire.data);
                end
                checkValue("retireMemWrite", {31'd0, retireMemWrite},
                           {31'd0, expRetire.memWrite});
                if (expRetire.memWrite) begin
                    checkValue("retireAddr", retireAddr, expRetire.addr);
                    checkValue("retireStoreData", retireStoreData, expRetire.storeData);
                end
                commitCount++;
            end
            if (commitCount == NUM_COMMITS) begin
                $display("No errors");
                $finish;
            end else if (cycleCount >= TIMEOUT_CYCLES) begin
                $display("Errors found");
                $fatal(1, "Timeout after %0d cycles with %0d commits", cycleCount, commitCount);
            end
        end
    end

endmodule

//--- vlog.f
source/mipsPkg.sv
source/ctrlIf.sv
source/controlUnit.sv
source/regFile.sv
source/executeUnit.sv
source/mipsCore.sv
testbench/clockGen.sv
testbench/mipsCore_assert.sv
testbench/mipsCoreTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = mipsCoreTb
FILELIST  = vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
